//--- Bender.yml
package:
  name: mem_subsys

sources:
  # Package first, then leaf modules, then the top level.
  - files:
      - hw/mem_chan_pkg.sv
      - hw/chan_mux_dynamic.sv
      - hw/mem_bank.sv
      - hw/mem_subsys_top.sv

  # Verification sources.
  - target: test
    files:
      - verif/mem_subsys_props.sv
      - verif/tb_mem_subsys.sv

//--- hw/chan_mux_dynamic.sv
// Round-robin channel multiplexer.
// Funnels NB_IN_CHAN request channels onto NB_OUT_CHAN bank ports. Channel k
// belongs to port k mod NB_OUT_CHAN, in slot k div NB_OUT_CHAN. A shared
// rotating counter sets the slot priority in every group, and each response
// is steered back to the channel that was granted one cycle before.

module chan_mux_dynamic
  import mem_chan_pkg::*;
#(
  parameter int unsigned NB_IN_CHAN  = 8,
  parameter int unsigned NB_OUT_CHAN = 2
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       clear,        // Resets the rotating counter.
  input  logic     [NB_IN_CHAN-1:0]  in_req,
  input  mem_req_t [NB_IN_CHAN-1:0]  in_payload,
  output logic     [NB_IN_CHAN-1:0]  in_gnt,
  output logic     [NB_IN_CHAN-1:0]  in_r_valid,
  output mem_rsp_t [NB_IN_CHAN-1:0]  in_rsp,
  output logic     [NB_OUT_CHAN-1:0] out_req,
  output mem_req_t [NB_OUT_CHAN-1:0] out_payload,
  input  logic     [NB_OUT_CHAN-1:0] out_gnt,
  input  logic     [NB_OUT_CHAN-1:0] out_r_valid,
  input  mem_rsp_t [NB_OUT_CHAN-1:0] out_rsp
);

  localparam int unsigned K      = NB_IN_CHAN / NB_OUT_CHAN;  // Slots per group.
  localparam int unsigned SLOT_W = (K > 1) ? $clog2(K) : 1;

  typedef logic [SLOT_W-1:0] slot_t;

  slot_t                   rr_q;        // Shared priority offset.
  logic                    rr_advance;
  slot_t [NB_OUT_CHAN-1:0] winner_d;    // Winning slot per port, this cycle.
  slot_t [NB_OUT_CHAN-1:0] winner_q;    // Winning slot of the previous cycle.
  logic  [NB_OUT_CHAN-1:0] req_q;       // Port had a request last cycle.

  // Rotate only when a grant happened while some request still lost.
  assign rr_advance = (|out_gnt) & (|(in_req & ~in_gnt));

  always_ff @(posedge clk_i or negedge rst_ni) begin : rr_counter
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (clear) begin
      rr_q <= '0;
    end else if (rr_advance) begin
      if (rr_q == slot_t'(K - 1)) begin
        rr_q <= '0;  // Wrap at K.
      end else begin
        rr_q <= rr_q + slot_t'(1);
      end
    end
  end

  // Port i scans slots starting at (rr_q + i) mod K; first requester wins.
  always_comb begin : winner_search
    int unsigned base;
    int unsigned slot;
    logic        found;
    base = rr_q;
    for (int unsigned i = 0; i < NB_OUT_CHAN; i++) begin
      out_req[i]  = 1'b0;
      found       = 1'b0;
      winner_d[i] = slot_t'((base + i) % K);  // Head slot when idle.
      for (int unsigned s = 0; s < K; s++) begin
        slot = (base + i + s) % K;
        if (in_req[slot*NB_OUT_CHAN+i]) begin
          out_req[i] = 1'b1;  // OR of the group.
          if (!found) begin
            winner_d[i] = slot_t'(slot);
            found       = 1'b1;
          end
        end
      end
    end
  end

  // Forward the winner's payload to its bank port.
  always_comb begin : payload_mux
    for (int unsigned i = 0; i < NB_OUT_CHAN; i++) begin
      out_payload[i] = in_payload[winner_d[i]*NB_OUT_CHAN+i];
    end
  end

  // Remember who was served, for the response one cycle later.
  always_ff @(posedge clk_i or negedge rst_ni) begin : winner_reg
    if (!rst_ni) begin
      winner_q <= '0;
      req_q    <= '0;
    end else begin
      winner_q <= winner_d;
      req_q    <= out_req;
    end
  end

  // Grant goes to this cycle's winner, response to last cycle's winner.
  always_comb begin : steer
    in_gnt     = '0;
    in_r_valid = '0;
    in_rsp     = '0;  // Losers see zero.
    for (int unsigned i = 0; i < NB_OUT_CHAN; i++) begin
      in_gnt[winner_d[i]*NB_OUT_CHAN+i]     = out_gnt[i];
      in_r_valid[winner_q[i]*NB_OUT_CHAN+i] = out_r_valid[i] & req_q[i];
      in_rsp[winner_q[i]*NB_OUT_CHAN+i]     = out_rsp[i];
    end
  end

endmodule

//--- hw/mem_bank.sv
// Single-port bank memory.
// Grants a request in its own cycle unless stalled. A write merges the
// enabled bytes into the addressed word; every grant returns the word held
// before the access one cycle later, with a one-cycle r_valid pulse.

module mem_bank
  import mem_chan_pkg::*;
#(
  parameter int unsigned BANK_WORDS = 256
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     req,
  input  mem_req_t payload,
  input  logic     stall,    // Back-pressure, holds gnt low.
  output logic     gnt,
  output logic     r_valid,
  output mem_rsp_t rsp
);

  localparam int unsigned IDX_W  = (BANK_WORDS > 1) ? $clog2(BANK_WORDS) : 1;
  localparam int unsigned BYTE_W = MEM_DW / MEM_BW;  // Bits per lane.

  logic [IDX_W-1:0] idx;
  data_t            mem_q [BANK_WORDS];
  data_t            rdata_q;
  logic             valid_q;

  assign gnt = req & ~stall;
  assign idx = payload.add[IDX_W-1:0];  // Word index inside the bank.

  // Byte-lane write.
  always_ff @(posedge clk_i) begin : mem_write
    if (gnt && !payload.wen) begin
      for (int unsigned b = 0; b < MEM_BW; b++) begin
        if (payload.be[b]) begin
          mem_q[idx][b*BYTE_W +: BYTE_W] <= payload.data[b*BYTE_W +: BYTE_W];
        end
      end
    end
  end

  // Old word is sampled on every grant, read or write.
  always_ff @(posedge clk_i or negedge rst_ni) begin : rsp_reg
    if (!rst_ni) begin
      valid_q <= 1'b0;
      rdata_q <= '0;
    end else begin
      valid_q <= gnt;
      if (gnt) begin
        rdata_q <= mem_q[idx];
      end
    end
  end

  assign r_valid    = valid_q;
  assign rsp.r_data = rdata_q;

endmodule

//--- hw/mem_chan_pkg.sv
// Memory channel package.
// Widths, vector types and the request and response payloads that are
// shared by the channel multiplexer, the banks and the top level.

package mem_chan_pkg;

  // Bank geometry.
  localparam int unsigned MEM_AW = 8;   // Word address bits inside a bank.
  localparam int unsigned MEM_DW = 32;  // Data word width.
  localparam int unsigned MEM_BW = 4;   // Byte lanes per word.

  typedef logic [MEM_AW-1:0] addr_t;  // Word address within a bank.
  typedef logic [MEM_DW-1:0] data_t;  // Data word.
  typedef logic [MEM_BW-1:0] be_t;    // Bit n enables byte n.

  // Request payload that travels with req, 45 bits.
  typedef struct packed {
    addr_t add;   // Word address.
    logic  wen;   // High for read, low for write.
    be_t   be;    // Byte enables for writes.
    data_t data;  // Write data.
  } mem_req_t;

  // Response payload that travels with r_valid.
  typedef struct packed {
    data_t r_data;  // Read data, or the old word on a write.
  } mem_rsp_t;

endpackage

//--- hw/mem_subsys_top.sv
// Shared-memory subsystem top level.
// Round-robin multiplexer from the request channels onto NB_OUT_CHAN
// single-port banks, one bank per multiplexer port.

module mem_subsys_top
  import mem_chan_pkg::*;
#(
  parameter int unsigned NB_IN_CHAN  = 8,
  parameter int unsigned NB_OUT_CHAN = 2,    // Must divide NB_IN_CHAN.
  parameter int unsigned BANK_WORDS  = 256
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       clear,
  input  logic     [NB_IN_CHAN-1:0]  in_req,
  input  mem_req_t [NB_IN_CHAN-1:0]  in_payload,
  input  logic     [NB_OUT_CHAN-1:0] bank_stall,  // One stall per bank.
  output logic     [NB_IN_CHAN-1:0]  in_gnt,
  output logic     [NB_IN_CHAN-1:0]  in_r_valid,
  output mem_rsp_t [NB_IN_CHAN-1:0]  in_rsp
);

  // Mux to bank ports.
  logic     [NB_OUT_CHAN-1:0] out_req;
  mem_req_t [NB_OUT_CHAN-1:0] out_payload;
  logic     [NB_OUT_CHAN-1:0] out_gnt;
  logic     [NB_OUT_CHAN-1:0] out_r_valid;
  mem_rsp_t [NB_OUT_CHAN-1:0] out_rsp;

  chan_mux_dynamic #(
    .NB_IN_CHAN  (NB_IN_CHAN),
    .NB_OUT_CHAN (NB_OUT_CHAN)
  ) i_mux (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear       (clear),
    .in_req      (in_req),
    .in_payload  (in_payload),
    .in_gnt      (in_gnt),
    .in_r_valid  (in_r_valid),
    .in_rsp      (in_rsp),
    .out_req     (out_req),
    .out_payload (out_payload),
    .out_gnt     (out_gnt),
    .out_r_valid (out_r_valid),
    .out_rsp     (out_rsp)
  );

  for (genvar i = 0; i < NB_OUT_CHAN; i++) begin : gen_bank
    mem_bank #(
      .BANK_WORDS (BANK_WORDS)
    ) i_bank (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req     (out_req[i]),
      .payload (out_payload[i]),
      .stall   (bank_stall[i]),
      .gnt     (out_gnt[i]),
      .r_valid (out_r_valid[i]),
      .rsp     (out_rsp[i])
    );
  end

endmodule

//--- project.f
hw/mem_chan_pkg.sv
hw/chan_mux_dynamic.sv
hw/mem_bank.sv
hw/mem_subsys_top.sv
verif/mem_subsys_props.sv
verif/tb_mem_subsys.sv

//--- verif/mem_subsys_props.sv
// Protocol properties of the channel multiplexer.
// Bound into every chan_mux_dynamic instance; checks grant uniqueness per
// bank group, grant against request, and the one-cycle response timing.

module mem_subsys_props #(
  parameter int unsigned NB_IN_CHAN  = 8,
  parameter int unsigned NB_OUT_CHAN = 2
) (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic [NB_IN_CHAN-1:0] in_req,
  input logic [NB_IN_CHAN-1:0] in_gnt,
  input logic [NB_IN_CHAN-1:0] in_r_valid
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned K = NB_IN_CHAN / NB_OUT_CHAN;  // Slots per group.

  int unsigned num_fails = 0;  // Property failures so far.

  for (genvar i = 0; i < NB_OUT_CHAN; i++) begin : gen_group
    logic [K-1:0] grp_gnt;  // Grants of the channels on port i.

    for (genvar s = 0; s < K; s++) begin : gen_slot
      assign grp_gnt[s] = in_gnt[s*NB_OUT_CHAN+i];
    end

    one_gnt_per_group : assert property (
      @(posedge clk_i) disable iff (!rst_ni) $onehot0(grp_gnt))
      else begin
        num_fails++;
        $error("More than one grant in bank group %0d", i);
      end
  end

  gnt_needs_req : assert property (
    @(posedge clk_i) disable iff (!rst_ni) (in_gnt & ~in_req) == '0)
    else begin
      num_fails++;
      $error("Grant given to a channel without a request");
    end

  // Response one cycle after the grant, on the same channel.
  rsp_follows_gnt : assert property (
    @(posedge clk_i) disable iff (!rst_ni) in_r_valid == $past(in_gnt))
    else begin
      num_fails++;
      $error("Read valid does not follow the grant by one cycle");
    end

endmodule

bind chan_mux_dynamic mem_subsys_props #(
  .NB_IN_CHAN  (NB_IN_CHAN),
  .NB_OUT_CHAN (NB_OUT_CHAN)
) i_props (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .in_req     (in_req),
  .in_gnt     (in_gnt),
  .in_r_valid (in_r_valid)
);

//--- verif/tb_mem_subsys.sv
// Testbench for the shared-memory subsystem.
// Applies a table of channel request steps, predicts every grant with a
// model of the round-robin rule and every response with a reference memory.

module tb_mem_subsys
  import mem_chan_pkg::*;
;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NB_IN_CHAN   = 8;
  localparam int unsigned NB_OUT_CHAN  = 2;
  localparam int unsigned BANK_WORDS   = 256;
  localparam int unsigned K            = NB_IN_CHAN / NB_OUT_CHAN;
  localparam int unsigned RESET_CYCLES = 10;

  typedef enum logic [1:0] {OP_RD, OP_WR, OP_WR_RND} op_e;

  // One table row, applied in one clock cycle.
  typedef struct packed {
    logic [NB_IN_CHAN-1:0]  req;    // Channels that start a new request.
    op_e                    op;
    addr_t                  addr;   // Base address plus the channel index.
    be_t                    be;
    data_t                  data;
    logic [NB_OUT_CHAN-1:0] stall;
    logic                   clr;
  } step_t;

  logic                       clk_i = 1'b0;
  logic                       rst_ni;
  logic                       clear;
  logic     [NB_IN_CHAN-1:0]  in_req;
  mem_req_t [NB_IN_CHAN-1:0]  in_payload;
  logic     [NB_OUT_CHAN-1:0] bank_stall;
  logic     [NB_IN_CHAN-1:0]  in_gnt;
  logic     [NB_IN_CHAN-1:0]  in_r_valid;
  mem_rsp_t [NB_IN_CHAN-1:0]  in_rsp;

  step_t       steps[$];
  integer      seed;
  int unsigned num_checks;
  int unsigned num_errors;
  int unsigned cycles = 0;
  int unsigned max_cycles = 1000;

  data_t                 ref_mem [NB_OUT_CHAN][BANK_WORDS];
  logic                  ref_known [NB_OUT_CHAN][BANK_WORDS];  // Word fully written.
  int unsigned           rr_m;          // Model of the rotating counter.
  logic [NB_IN_CHAN-1:0] exp_rv;        // Grants of the previous cycle.
  data_t                 exp_rd [NB_IN_CHAN];
  logic [NB_IN_CHAN-1:0] exp_rd_known;
  logic [NB_IN_CHAN-1:0] last_gnt;

  mem_subsys_top #(
    .NB_IN_CHAN  (NB_IN_CHAN),
    .NB_OUT_CHAN (NB_OUT_CHAN),
    .BANK_WORDS  (BANK_WORDS)
  ) UUT (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .clear      (clear),
    .in_req     (in_req),
    .in_payload (in_payload),
    .bank_stall (bank_stall),
    .in_gnt     (in_gnt),
    .in_r_valid (in_r_valid),
    .in_rsp     (in_rsp)
  );

  always #2 clk_i = ~clk_i;  // 4 ns period.

  always @(posedge clk_i) begin : watchdog
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("Timeout: the test did not finish within %0d cycles", max_cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    num_checks++;
    if (got !== exp) begin
      num_errors++;
      $display("ERROR %0d ns: %s: got 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic add_step(input logic [NB_IN_CHAN-1:0] req, input op_e op,
                          input addr_t addr, input be_t be, input data_t data,
                          input logic [NB_OUT_CHAN-1:0] stall, input logic clr);
    steps.push_back('{req, op, addr, be, data, stall, clr});
  endtask

  task automatic add_idle(input int unsigned n);
    repeat (n) add_step('0, OP_RD, '0, '0, '0, '0, 1'b0);
  endtask

  task automatic build_table();
    add_idle(2);
    add_step(8'h08, OP_WR, 8'h10, 4'hf, 32'hcafe_f00d, 2'b00, 1'b0);  // Lone channel.
    add_step(8'h08, OP_RD, 8'h10, 4'hf, 32'h0, 2'b00, 1'b0);
    add_idle(1);
    add_step(8'h20, OP_WR, 8'h20, 4'hf, 32'h1122_3344, 2'b00, 1'b0);  // Byte merge.
    add_step(8'h20, OP_WR, 8'h20, 4'h5, 32'haabb_ccdd, 2'b00, 1'b0);
    add_step(8'h20, OP_WR, 8'h20, 4'h8, 32'h5566_7788, 2'b00, 1'b0);
    add_step(8'h20, OP_RD, 8'h20, 4'hf, 32'h0, 2'b00, 1'b0);
    add_idle(1);
    repeat (4) add_step(8'hff, OP_WR_RND, 8'h40, 4'hf, '0, 2'b00, 1'b0);
    repeat (4) add_step(8'hff, OP_RD, 8'h40, 4'hf, '0, 2'b00, 1'b0);
    repeat (4) add_step(8'hff, OP_RD, 8'h40, 4'hf, '0, 2'b01, 1'b0);  // Bank 0 stalled.
    repeat (4) add_step(8'hff, OP_RD, 8'h40, 4'hf, '0, 2'b00, 1'b0);
    add_step(8'hff, OP_RD, 8'h40, 4'hf, '0, 2'b00, 1'b1);              // Clear pulse.
    repeat (2) add_step(8'hff, OP_RD, 8'h40, 4'hf, '0, 2'b00, 1'b0);
    add_idle(5);  // Let held requests drain.
  endtask

  function automatic mem_req_t new_payload(input step_t s, input int unsigned k);
    mem_req_t p;
    p.add  = s.addr + addr_t'(k);
    p.wen  = (s.op == OP_RD);
    p.be   = s.be;
    p.data = (s.op == OP_WR_RND) ? data_t'($random(seed)) : s.data;
    return p;
  endfunction

  // Port i scans its slots from (rr + i) mod K; first requester wins.
  function automatic logic [NB_IN_CHAN-1:0] predict_grants(
      input logic [NB_IN_CHAN-1:0] req, input logic [NB_OUT_CHAN-1:0] stall,
      input int unsigned rr);
    logic [NB_IN_CHAN-1:0] gnt;
    logic                  found;
    int unsigned           ch;
    gnt = '0;
    for (int unsigned i = 0; i < NB_OUT_CHAN; i++) begin
      found = 1'b0;
      for (int unsigned s = 0; s < K; s++) begin
        ch = ((rr + i + s) % K) * NB_OUT_CHAN + i;
        if (!stall[i] && !found && req[ch]) begin
          gnt[ch] = 1'b1;
          found   = 1'b1;
        end
      end
    end
    return gnt;
  endfunction

  // A channel holds its request until granted, then takes the next row.
  task automatic apply_step(input step_t s);
    for (int unsigned k = 0; k < NB_IN_CHAN; k++) begin
      if (!in_req[k] || last_gnt[k]) begin
        in_req[k] <= s.req[k];
        if (s.req[k]) begin
          in_payload[k] <= new_payload(s, k);
        end
      end
    end
    bank_stall <= s.stall;
    clear      <= s.clr;
  endtask

  task automatic check_cycle(input int unsigned n);
    logic [NB_IN_CHAN-1:0] exp_gnt;
    int unsigned           b;
    addr_t                 a;
    exp_gnt = predict_grants(in_req, bank_stall, rr_m);
    check_value($sformatf("step %0d grants", n), in_gnt, exp_gnt);
    check_value($sformatf("step %0d read valids", n), in_r_valid, exp_rv);
    for (int unsigned k = 0; k < NB_IN_CHAN; k++) begin
      if (exp_rv[k] && exp_rd_known[k]) begin
        check_value($sformatf("step %0d channel %0d data", n, k),
                    in_rsp[k].r_data, exp_rd[k]);
      end
    end
    for (int unsigned k = 0; k < NB_IN_CHAN; k++) begin
      if (exp_gnt[k]) begin
        b               = k % NB_OUT_CHAN;
        a               = in_payload[k].add;
        exp_rd[k]       = ref_mem[b][a];  // Old word for reads and writes.
        exp_rd_known[k] = ref_known[b][a];
        if (!in_payload[k].wen) begin
          for (int unsigned j = 0; j < MEM_BW; j++) begin
            if (in_payload[k].be[j]) begin
              ref_mem[b][a][8*j +: 8] = in_payload[k].data[8*j +: 8];
            end
          end
          if (&in_payload[k].be) begin
            ref_known[b][a] = 1'b1;
          end
        end
      end
    end
    exp_rv   = exp_gnt;
    last_gnt = in_gnt;
    if (clear) begin
      rr_m = 0;
    end else if (|exp_gnt && |(in_req & ~exp_gnt)) begin
      rr_m = (rr_m + 1) % K;  // Advance on contention.
    end
  endtask

  initial begin : main
    rst_ni       = 1'b0;
    clear        = 1'b0;
    in_req       = '0;
    in_payload   = '0;
    bank_stall   = '0;
    seed         = 32'heaba_f859;
    num_checks   = 0;
    num_errors   = 0;
    rr_m         = 0;
    exp_rv       = '0;
    exp_rd_known = '0;
    last_gnt     = '0;
    for (int unsigned b = 0; b < NB_OUT_CHAN; b++) begin
      for (int unsigned w = 0; w < BANK_WORDS; w++) begin
        ref_known[b][w] = 1'b0;
      end
    end
    build_table();
    max_cycles = steps.size() * 8 + RESET_CYCLES;

    repeat (RESET_CYCLES - 1) @(posedge clk_i);
    @(negedge clk_i);
    check_value("grants in reset", in_gnt, '0);
    check_value("read valids in reset", in_r_valid, '0);
    @(posedge clk_i);
    rst_ni <= 1'b1;

    foreach (steps[n]) begin
      @(posedge clk_i);
      apply_step(steps[n]);
      @(negedge clk_i);
      check_cycle(n);
    end

    $display("Checks: %0d, errors: %0d, assertion failures: %0d", num_checks, num_errors,
             UUT.i_mux.i_props.num_fails);
    if (num_errors == 0 && UUT.i_mux.i_props.num_fails == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
